/* src/cam_pkg.sv */
package cam_pkg;

    //////////////////////////////////////////////////
    // Client channels

    localparam int CHANNEL_COUNT = 2;   // Fixed, two peer channels
    localparam int SOURCE_BITS   = $clog2(CHANNEL_COUNT);

    //////////////////////////////////////////////////
    // Operations

    typedef enum logic [1:0]
    {
        op_lookup = 2'd0,   // Search by key
        op_insert = 2'd1,   // Write at victim pointer
        op_read   = 2'd2    // Read by index
    } cam_op_e;

    //////////////////////////////////////////////////
    // Control structs, data fields travel separately

    // Request level held until grant
    typedef struct packed
    {
        logic    valid;
        cam_op_e op;
    } cam_req_ctrl_t;

    // Response, valid is a one-cycle pulse
    typedef struct packed
    {
        logic                     valid;
        cam_op_e                  op;
        logic [SOURCE_BITS - 1:0] source;   // Requesting channel
        logic                     hit;
    } cam_rsp_ctrl_t;

endpackage

/* src/find_first_one_index.sv */
module find_first_one_index
#(
    parameter int VECTOR_LENGTH    = 4,
    parameter int MAX_OUTPUT_WIDTH = 2
)
(
    input  logic [VECTOR_LENGTH - 1:0]    vector_in,
    output logic [MAX_OUTPUT_WIDTH - 1:0] first_one_index_out,
    output logic                          one_is_found_out
);

    // Scan downward so the lowest set bit is written last
    always_comb
    begin
        first_one_index_out = '0;   // Zero when nothing is set
        one_is_found_out    = 1'b0;

        for (int i = VECTOR_LENGTH - 1; i >= 0; i--)
        begin
            if (vector_in[i])
            begin
                first_one_index_out = MAX_OUTPUT_WIDTH'(i);
                one_is_found_out    = 1'b1;
            end
        end
    end

endmodule

/* src/tri_port_regfile.sv */
module tri_port_regfile
#(
    parameter int ENTRY_BITS  = 8,
    parameter int ENTRY_COUNT = 4,
    localparam int INDEX_BITS = $clog2(ENTRY_COUNT)
)
(
    input  logic                       reset_in,
    input  logic                       clk_in,

    input  logic                       read_en_in,
    input  logic                       write_en_in,
    input  logic                       cam_en_in,

    input  logic [ENTRY_COUNT - 1:0]   read_entry_addr_decoded_in,
    input  logic [ENTRY_COUNT - 1:0]   write_entry_addr_decoded_in,
    input  logic [ENTRY_BITS - 1:0]    cam_entry_in,
    input  logic [ENTRY_BITS - 1:0]    write_entry_in,

    output logic [ENTRY_BITS - 1:0]    read_entry_out,
    output logic [ENTRY_COUNT - 1:0]   cam_result_decoded_out
);

    logic [ENTRY_BITS - 1:0] entries [ENTRY_COUNT];
    logic [INDEX_BITS - 1:0] read_index;
    logic                    read_index_found;

    //////////////////////////////////////////////////
    // Write port and search port

    // Unwritten entries must read as zero, hence the clear on reset
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            for (int i = 0; i < ENTRY_COUNT; i++)
            begin
                entries[i] <= '0;
            end
            cam_result_decoded_out <= '0;
        end
        else
        begin
            for (int i = 0; i < ENTRY_COUNT; i++)
            begin
                if (write_en_in && write_entry_addr_decoded_in[i])
                begin
                    entries[i] <= write_entry_in;
                end

                // Compares against contents before this cycle's write
                cam_result_decoded_out[i] <= cam_en_in && (entries[i] == cam_entry_in);
            end
        end
    end

    //////////////////////////////////////////////////
    // Read port

    find_first_one_index
    #(
        .VECTOR_LENGTH    (ENTRY_COUNT),
        .MAX_OUTPUT_WIDTH (INDEX_BITS)
    )
    read_index_encoder
    (
        .vector_in           (read_entry_addr_decoded_in),
        .first_one_index_out (read_index),
        .one_is_found_out    (read_index_found)
    );

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            read_entry_out <= '0;
        end
        else if (read_en_in && read_index_found)
        begin
            read_entry_out <= entries[read_index];
        end
        else
        begin
            read_entry_out <= '0;   // Idle read gives zero
        end
    end

endmodule

/* src/cam_request_arbiter.sv */
module cam_request_arbiter
#(
    parameter int ENTRY_BITS = 8
)
(
    input  logic                                                clk_in,
    input  logic                                                reset_in,

    input  cam_pkg::cam_req_ctrl_t [cam_pkg::CHANNEL_COUNT - 1:0] req_ctrl,
    input  logic [cam_pkg::CHANNEL_COUNT - 1:0][ENTRY_BITS - 1:0] req_operand,

    output logic [cam_pkg::CHANNEL_COUNT - 1:0]                 grant,
    output cam_pkg::cam_req_ctrl_t                              granted_ctrl,
    output logic [ENTRY_BITS - 1:0]                             granted_operand,
    output logic [cam_pkg::SOURCE_BITS - 1:0]                   granted_source
);

    logic [cam_pkg::SOURCE_BITS - 1:0] last_granted;

    // Search starts one past the last winner
    always_comb
    begin
        int   channel;
        logic taken;

        grant           = '0;
        granted_ctrl    = '0;
        granted_operand = '0;
        granted_source  = '0;
        taken           = 1'b0;

        for (int offset = 1; offset <= cam_pkg::CHANNEL_COUNT; offset++)
        begin
            channel = (int'(last_granted) + offset) % cam_pkg::CHANNEL_COUNT;
            if (!taken && req_ctrl[channel].valid)
            begin
                taken            = 1'b1;
                grant[channel]   = 1'b1;
                granted_ctrl     = req_ctrl[channel];
                granted_operand  = req_operand[channel];
                granted_source   = cam_pkg::SOURCE_BITS'(channel);
            end
        end
    end

    // Channel 0 wins the first contention
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            last_granted <= cam_pkg::SOURCE_BITS'(cam_pkg::CHANNEL_COUNT - 1);
        end
        else if (granted_ctrl.valid)
        begin
            last_granted <= granted_source;
        end
    end

endmodule

/* src/cam_table_controller.sv */
module cam_table_controller
#(
    parameter int ENTRY_BITS  = 8,
    parameter int ENTRY_COUNT = 4,
    localparam int INDEX_BITS = $clog2(ENTRY_COUNT)
)
(
    input  logic                              clk_in,
    input  logic                              reset_in,

    input  cam_pkg::cam_req_ctrl_t            granted_ctrl,
    input  logic [ENTRY_BITS - 1:0]           granted_operand,
    input  logic [cam_pkg::SOURCE_BITS - 1:0] granted_source,
    input  logic [ENTRY_BITS - 1:0]           read_entry,
    input  logic [ENTRY_COUNT - 1:0]          cam_result,

    output logic                              read_en,
    output logic                              write_en,
    output logic                              cam_en,
    output logic [ENTRY_COUNT - 1:0]          read_addr_decoded,
    output logic [ENTRY_COUNT - 1:0]          write_addr_decoded,
    output logic [ENTRY_BITS - 1:0]           cam_key,
    output logic [ENTRY_BITS - 1:0]           write_word,

    output cam_pkg::cam_rsp_ctrl_t            rsp_ctrl,
    output logic [INDEX_BITS - 1:0]           rsp_index,
    output logic [ENTRY_BITS - 1:0]           rsp_word
);

    logic [INDEX_BITS - 1:0]           victim_ptr;
    logic [INDEX_BITS - 1:0]           request_index;

    cam_pkg::cam_req_ctrl_t            stage_ctrl;
    logic [cam_pkg::SOURCE_BITS - 1:0] stage_source;
    logic [INDEX_BITS - 1:0]           stage_index;
    logic [ENTRY_BITS - 1:0]           stage_word;

    logic [INDEX_BITS - 1:0]           hit_index;
    logic                              hit_found;

    //////////////////////////////////////////////////
    // Request decode

    assign read_en  = granted_ctrl.valid && (granted_ctrl.op == cam_pkg::op_read);
    assign write_en = granted_ctrl.valid && (granted_ctrl.op == cam_pkg::op_insert);
    assign cam_en   = granted_ctrl.valid && (granted_ctrl.op == cam_pkg::op_lookup);

    assign request_index      = granted_operand[INDEX_BITS - 1:0];   // Read index in low bits
    assign read_addr_decoded  = ENTRY_COUNT'(1) << request_index;
    assign write_addr_decoded = ENTRY_COUNT'(1) << victim_ptr;
    assign cam_key            = granted_operand;
    assign write_word         = granted_operand;

    // Round-robin replacement
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            victim_ptr <= '0;
        end
        else if (write_en)
        begin
            if (victim_ptr == INDEX_BITS'(ENTRY_COUNT - 1))
                victim_ptr <= '0;
            else
                victim_ptr <= victim_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // One-stage record, aligned with regfile outputs

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            stage_ctrl   <= '0;
            stage_source <= '0;
        end
        else
        begin
            stage_ctrl   <= granted_ctrl;
            stage_source <= granted_source;
        end
    end

    always_ff @(posedge clk_in)
    begin
        stage_index <= write_en ? victim_ptr : request_index;
        stage_word  <= granted_operand;
    end

    find_first_one_index
    #(
        .VECTOR_LENGTH    (ENTRY_COUNT),
        .MAX_OUTPUT_WIDTH (INDEX_BITS)
    )
    hit_index_encoder
    (
        .vector_in           (cam_result),
        .first_one_index_out (hit_index),
        .one_is_found_out    (hit_found)
    );

    //////////////////////////////////////////////////
    // Response

    always_comb
    begin
        rsp_ctrl.valid  = stage_ctrl.valid;
        rsp_ctrl.op     = stage_ctrl.op;
        rsp_ctrl.source = stage_source;
        rsp_ctrl.hit    = stage_ctrl.valid;   // Insert and read always hit
        rsp_index       = stage_index;
        rsp_word        = '0;

        case (stage_ctrl.op)
            cam_pkg::op_lookup:
            begin
                rsp_ctrl.hit = stage_ctrl.valid && hit_found;
                rsp_index    = hit_index;   // Lowest match, zero on miss
            end
            cam_pkg::op_insert:
            begin
                rsp_word = stage_word;
            end
            cam_pkg::op_read:
            begin
                rsp_word = read_entry;
            end
            default:
            begin
                rsp_word = '0;
            end
        endcase
    end

endmodule

/* src/cam_lookup_table.sv */
module cam_lookup_table
#(
    parameter int ENTRY_BITS  = 8,
    parameter int ENTRY_COUNT = 4,
    localparam int INDEX_BITS = $clog2(ENTRY_COUNT)
)
(
    input  logic                                                  clk_in,
    input  logic                                                  reset_in,

    input  cam_pkg::cam_req_ctrl_t [cam_pkg::CHANNEL_COUNT - 1:0] req_ctrl,
    input  logic [cam_pkg::CHANNEL_COUNT - 1:0][ENTRY_BITS - 1:0] req_operand,

    output logic [cam_pkg::CHANNEL_COUNT - 1:0]                   grant,
    output cam_pkg::cam_rsp_ctrl_t                                rsp_ctrl,
    output logic [INDEX_BITS - 1:0]                               rsp_index,
    output logic [ENTRY_BITS - 1:0]                               rsp_word
);

    cam_pkg::cam_req_ctrl_t            granted_ctrl;
    logic [ENTRY_BITS - 1:0]           granted_operand;
    logic [cam_pkg::SOURCE_BITS - 1:0] granted_source;

    logic                              read_en;
    logic                              write_en;
    logic                              cam_en;
    logic [ENTRY_COUNT - 1:0]          read_addr_decoded;
    logic [ENTRY_COUNT - 1:0]          write_addr_decoded;
    logic [ENTRY_BITS - 1:0]           cam_key;
    logic [ENTRY_BITS - 1:0]           write_word;
    logic [ENTRY_BITS - 1:0]           read_entry;
    logic [ENTRY_COUNT - 1:0]          cam_result;

    cam_request_arbiter
    #(
        .ENTRY_BITS (ENTRY_BITS)
    )
    arbiter
    (
        .clk_in          (clk_in),
        .reset_in        (reset_in),
        .req_ctrl        (req_ctrl),
        .req_operand     (req_operand),
        .grant           (grant),
        .granted_ctrl    (granted_ctrl),
        .granted_operand (granted_operand),
        .granted_source  (granted_source)
    );

    cam_table_controller
    #(
        .ENTRY_BITS  (ENTRY_BITS),
        .ENTRY_COUNT (ENTRY_COUNT)
    )
    controller
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .granted_ctrl       (granted_ctrl),
        .granted_operand    (granted_operand),
        .granted_source     (granted_source),
        .read_entry         (read_entry),
        .cam_result         (cam_result),
        .read_en            (read_en),
        .write_en           (write_en),
        .cam_en             (cam_en),
        .read_addr_decoded  (read_addr_decoded),
        .write_addr_decoded (write_addr_decoded),
        .cam_key            (cam_key),
        .write_word         (write_word),
        .rsp_ctrl           (rsp_ctrl),
        .rsp_index          (rsp_index),
        .rsp_word           (rsp_word)
    );

    tri_port_regfile
    #(
        .ENTRY_BITS  (ENTRY_BITS),
        .ENTRY_COUNT (ENTRY_COUNT)
    )
    regfile
    (
        .reset_in                    (reset_in),
        .clk_in                      (clk_in),
        .read_en_in                  (read_en),
        .write_en_in                 (write_en),
        .cam_en_in                   (cam_en),
        .read_entry_addr_decoded_in  (read_addr_decoded),
        .write_entry_addr_decoded_in (write_addr_decoded),
        .cam_entry_in                (cam_key),
        .write_entry_in              (write_word),
        .read_entry_out              (read_entry),
        .cam_result_decoded_out      (cam_result)
    );

endmodule

/* verification/cam_sva.sv */
module cam_sva
(
    input  logic                                                  clk_in,
    input  logic                                                  reset_in,
    input  cam_pkg::cam_req_ctrl_t [cam_pkg::CHANNEL_COUNT - 1:0] req_ctrl,
    input  logic [cam_pkg::CHANNEL_COUNT - 1:0]                   grant
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [cam_pkg::CHANNEL_COUNT - 1:0] requesting;
    int                                  failures;

    always_comb
    begin
        for (int i = 0; i < cam_pkg::CHANNEL_COUNT; i++)
        begin
            requesting[i] = req_ctrl[i].valid;
        end
    end

    //////////////////////////////////////////////////
    // Grant properties

    grant_at_most_one: assert property (@(posedge clk_in) disable iff (reset_in)
        $onehot0(grant))
    else
    begin
        failures++;
        $error("grant has more than one bit set");
    end

    grant_only_to_requester: assert property (@(posedge clk_in) disable iff (reset_in)
        (grant & ~requesting) == '0)
    else
    begin
        failures++;
        $error("grant given to a channel without a request");
    end

endmodule

bind cam_request_arbiter cam_sva arbiter_checks
(
    .clk_in   (clk_in),
    .reset_in (reset_in),
    .req_ctrl (req_ctrl),
    .grant    (grant)
);

/* verification/cam_checker.sv */
module cam_checker
#(
    parameter int ENTRY_BITS  = 8,
    parameter int ENTRY_COUNT = 4,
    localparam int INDEX_BITS = $clog2(ENTRY_COUNT)
)
(
    input  logic                    clk_in,
    input  cam_pkg::cam_rsp_ctrl_t  rsp_ctrl,
    input  logic [INDEX_BITS - 1:0] rsp_index,
    input  logic [ENTRY_BITS - 1:0] rsp_word,
    input  cam_pkg::cam_rsp_ctrl_t  exp_ctrl,
    input  logic [INDEX_BITS - 1:0] exp_index,
    input  logic [ENTRY_BITS - 1:0] exp_word,
    input  int                      exp_test,
    output int                      pass_count,
    output int                      fail_count,
    output int                      pending_count
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed
    {
        int                      test;
        int                      due;    // Cycle the response belongs to
        cam_pkg::cam_rsp_ctrl_t  ctrl;
        logic [INDEX_BITS - 1:0] index;
        logic [ENTRY_BITS - 1:0] word;
    } expected_t;

    expected_t pending [cam_pkg::CHANNEL_COUNT][$];
    int        cycle;

    function automatic int field_mismatch(input int test, input string name,
                                          input logic [31:0] expected,
                                          input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("error test %0d %s expected 0x%0h got 0x%0h", test, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // Mid-cycle sampling, all DUT outputs settled
    always @(negedge clk_in)
    begin
        expected_t entry;
        int        errors;
        int        source;

        cycle++;
        if (exp_ctrl.valid)
        begin
            entry.test  = exp_test;
            entry.due   = cycle;
            entry.ctrl  = exp_ctrl;
            entry.index = exp_index;
            entry.word  = exp_word;
            pending[exp_ctrl.source].push_back(entry);
        end

        if (rsp_ctrl.valid)
        begin
            source = int'(rsp_ctrl.source);
            if (pending[source].size() == 0)
            begin
                $display("unexpected response from channel %0d with no request outstanding",
                         source);
                fail_count++;
            end
            else
            begin
                entry  = pending[source].pop_front();
                errors = field_mismatch(entry.test, "rsp_ctrl.op", 32'(entry.ctrl.op),
                                        32'(rsp_ctrl.op));
                errors += field_mismatch(entry.test, "rsp_ctrl.hit", 32'(entry.ctrl.hit),
                                         32'(rsp_ctrl.hit));
                if (entry.ctrl.hit || entry.ctrl.op != cam_pkg::op_lookup)   // Miss index unused
                begin
                    errors += field_mismatch(entry.test, "rsp_index", 32'(entry.index),
                                             32'(rsp_index));
                end
                errors += field_mismatch(entry.test, "rsp_word", 32'(entry.word),
                                         32'(rsp_word));
                if (errors == 0)
                begin
                    $display("test %0d passed on channel %0d", entry.test, source);
                    pass_count++;
                end
                else
                begin
                    $display("test %0d failed on channel %0d", entry.test, source);
                    fail_count++;
                end
            end
        end

        // Anything older than this cycle missed its one-cycle latency
        pending_count = 0;
        for (int s = 0; s < cam_pkg::CHANNEL_COUNT; s++)
        begin
            while (pending[s].size() != 0 && pending[s][0].due < cycle)
            begin
                entry = pending[s].pop_front();
                $display("test %0d got no response in the cycle after its grant", entry.test);
                fail_count++;
            end
            pending_count += pending[s].size();
        end
    end

endmodule

/* verification/cam_tb.sv */
module cam_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    ENTRY_BITS      = 8;
    localparam int    ENTRY_COUNT     = 4;
    localparam int    INDEX_BITS      = $clog2(ENTRY_COUNT);
    localparam int    CLOCK_PERIOD    = 4;
    localparam int    DRIVE_DELAY     = 1;
    localparam int    RESET_CYCLES    = 10;
    localparam int    CYCLES_PER_TEST = 20;
    localparam int    MAX_TESTS       = 64;
    localparam string STIMULUS_PATH   = "verification/cam_stimulus.txt";

    // One line of the stimulus file
    typedef struct packed
    {
        logic [cam_pkg::SOURCE_BITS - 1:0] channel;
        cam_pkg::cam_op_e                  op;
        logic [ENTRY_BITS - 1:0]           operand;
        logic                              together;
        logic                              hit;
        logic [INDEX_BITS - 1:0]           index;
        logic [ENTRY_BITS - 1:0]           word;
    } test_line_t;

    logic                                                  clk_in;
    logic                                                  reset_in;
    cam_pkg::cam_req_ctrl_t [cam_pkg::CHANNEL_COUNT - 1:0] req_ctrl;
    logic [cam_pkg::CHANNEL_COUNT - 1:0][ENTRY_BITS - 1:0] req_operand;
    logic [cam_pkg::CHANNEL_COUNT - 1:0]                   grant;
    cam_pkg::cam_rsp_ctrl_t                                rsp_ctrl;
    logic [INDEX_BITS - 1:0]                               rsp_index;
    logic [ENTRY_BITS - 1:0]                               rsp_word;

    cam_pkg::cam_rsp_ctrl_t  exp_ctrl;   // Record for the grant just taken
    logic [INDEX_BITS - 1:0] exp_index;
    logic [ENTRY_BITS - 1:0] exp_word;
    int                      exp_test;
    int                      pass_count;
    int                      fail_count;
    int                      pending_count;

    test_line_t tests [MAX_TESTS];
    int         test_count;
    logic       tests_loaded;
    int         last_winner;

    cam_lookup_table
    #(
        .ENTRY_BITS  (ENTRY_BITS),
        .ENTRY_COUNT (ENTRY_COUNT)
    )
    dut
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .req_ctrl    (req_ctrl),
        .req_operand (req_operand),
        .grant       (grant),
        .rsp_ctrl    (rsp_ctrl),
        .rsp_index   (rsp_index),
        .rsp_word    (rsp_word)
    );

    cam_checker
    #(
        .ENTRY_BITS  (ENTRY_BITS),
        .ENTRY_COUNT (ENTRY_COUNT)
    )
    response_checker
    (
        .clk_in        (clk_in),
        .rsp_ctrl      (rsp_ctrl),
        .rsp_index     (rsp_index),
        .rsp_word      (rsp_word),
        .exp_ctrl      (exp_ctrl),
        .exp_index     (exp_index),
        .exp_word      (exp_word),
        .exp_test      (exp_test),
        .pass_count    (pass_count),
        .fail_count    (fail_count),
        .pending_count (pending_count)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk_in = ~clk_in;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers

    task automatic load_tests();
        int    fd;
        string line;
        int    channel;
        int    op;
        int    operand;
        int    together;
        int    hit;
        int    index;
        int    word;

        fd = $fopen(STIMULUS_PATH, "r");
        if (fd == 0)
        begin
            return;
        end
        while (!$feof(fd) && test_count < MAX_TESTS)
        begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines fail the scan
            if ($sscanf(line, "%h %h %h %h %h %h %h", channel, op, operand, together,
                        hit, index, word) == 7)
            begin
                tests[test_count].channel  = cam_pkg::SOURCE_BITS'(channel);
                tests[test_count].op       = cam_pkg::cam_op_e'(op);
                tests[test_count].operand  = ENTRY_BITS'(operand);
                tests[test_count].together = 1'(together);
                tests[test_count].hit      = 1'(hit);
                tests[test_count].index    = INDEX_BITS'(index);
                tests[test_count].word     = ENTRY_BITS'(word);
                test_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic hand_over(input int test);
        exp_ctrl.valid  = 1'b1;
        exp_ctrl.op     = tests[test].op;
        exp_ctrl.source = tests[test].channel;
        exp_ctrl.hit    = tests[test].hit;
        exp_index       = tests[test].index;
        exp_word        = tests[test].word;
        exp_test        = test + 1;
    endtask

    // With both channels waiting, the one not granted last wins
    function automatic int round_robin_winner(
        input logic [cam_pkg::CHANNEL_COUNT - 1:0] waiting,
        input int                                  last
    );
        int winner;

        winner = -1;
        for (int c = 0; c < cam_pkg::CHANNEL_COUNT; c++)
        begin
            if (waiting[c] && (winner < 0 || c != last))
            begin
                winner = c;
            end
        end
        return winner;
    endfunction

    // Holds each request until its grant, one or two channels at once
    task automatic run_group(input int first, input logic paired);
        logic [cam_pkg::CHANNEL_COUNT - 1:0] waiting;
        int                                  owner [cam_pkg::CHANNEL_COUNT];
        int                                  granted;
        int                                  winner;
        int                                  line;

        waiting = '0;
        for (int k = 0; k <= int'(paired); k++)
        begin
            line                                   = first + k;
            req_ctrl[tests[line].channel].valid    = 1'b1;
            req_ctrl[tests[line].channel].op       = tests[line].op;
            req_operand[tests[line].channel]       = tests[line].operand;
            waiting[tests[line].channel]           = 1'b1;
            owner[tests[line].channel]             = line;
        end
        while (waiting != '0)
        begin
            @(negedge clk_in);
            granted = -1;
            for (int c = 0; c < cam_pkg::CHANNEL_COUNT; c++)
            begin
                if (waiting[c] && grant[c])
                begin
                    granted = c;
                end
            end
            @(posedge clk_in);
            #DRIVE_DELAY;
            if (granted >= 0)
            begin
                // Record of the channel that should have won this grant
                winner = round_robin_winner(waiting, last_winner);
                hand_over(owner[winner]);
                last_winner       = winner;
                req_ctrl[granted] = '0;
                waiting[granted]  = 1'b0;
            end
            else
            begin
                exp_ctrl.valid = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        int i;
        int assertion_failures;

        reset_in     = 1'b1;
        req_ctrl     = '0;
        req_operand  = '0;
        exp_ctrl     = '0;
        exp_index    = '0;
        exp_word     = '0;
        exp_test     = 0;
        test_count   = 0;
        last_winner  = cam_pkg::CHANNEL_COUNT - 1;
        load_tests();
        tests_loaded = 1'b1;

        if (test_count == 0)
        begin
            $display("no tests could be read from %s", STIMULUS_PATH);
            $display("Simulation finished: FAIL");
            $finish;
        end
        else
        begin
            repeat (RESET_CYCLES) @(posedge clk_in);
            #DRIVE_DELAY;
            reset_in = 1'b0;
            repeat (3) @(posedge clk_in);   // Idle, no response may appear
            #DRIVE_DELAY;

            i = 0;
            while (i < test_count)
            begin
                if (tests[i].together && i + 1 < test_count)
                begin
                    run_group(i, 1'b1);
                    i += 2;
                end
                else
                begin
                    run_group(i, 1'b0);
                    i++;
                end
            end
            @(posedge clk_in);
            #DRIVE_DELAY;
            exp_ctrl.valid = 1'b0;

            while (pending_count != 0)
            begin
                @(posedge clk_in);
            end
            repeat (4) @(posedge clk_in);   // Catch stray responses
            #DRIVE_DELAY;

            assertion_failures = dut.arbiter.arbiter_checks.failures;
            $display("tests %0d passed %0d failed %0d assertion failures %0d",
                     test_count, pass_count, fail_count, assertion_failures);
            if (fail_count == 0 && pass_count == test_count && assertion_failures == 0)
            begin
                $display("Simulation finished: PASS");
            end
            else
            begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

    // Watchdog
    initial
    begin
        int limit;

        wait (tests_loaded === 1'b1);
        limit = test_count * CYCLES_PER_TEST + RESET_CYCLES;
        repeat (limit) @(posedge clk_in);
        $display("timeout after %0d cycles with responses still missing", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verification/cam_stimulus.txt */
# ch op operand together hit index word (all hex, op 0 lookup 1 insert 2 read)
# together=1 issues the next line on the other channel in the same cycle
0 0 5a 0 0 0 00
1 0 00 0 1 0 00
1 1 11 0 1 0 11
0 1 22 0 1 1 22
0 1 33 0 1 2 33
1 1 44 0 1 3 44
0 0 33 0 1 2 00
1 0 11 0 1 0 00
0 2 01 0 1 1 22
1 2 03 0 1 3 44
0 0 77 0 0 0 00
1 1 22 0 1 0 22
0 0 22 0 1 0 00
1 2 00 0 1 0 22
0 0 11 0 0 0 00
1 2 02 0 1 2 33
0 1 55 1 1 1 55
1 1 66 0 1 2 66
0 2 01 0 1 1 55
0 1 88 1 1 0 88
1 1 99 0 1 3 99
0 0 99 1 1 3 00
1 0 88 0 1 0 00
0 2 00 0 1 0 88
0 2 02 0 1 2 66
1 2 03 0 1 3 99
1 0 66 0 1 2 00
0 0 00 0 0 0 00

/* files.f */
src/cam_pkg.sv
src/find_first_one_index.sv
src/tri_port_regfile.sv
src/cam_request_arbiter.sv
src/cam_table_controller.sv
src/cam_lookup_table.sv
verification/cam_sva.sv
verification/cam_checker.sv
verification/cam_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the CAM lookup table testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="Simulation finished: FAIL"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module cam_tb -f files.f --Mdir "$BUILD_DIR" -o cam_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/cam_sim" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
    echo "Failure reported, see $LOG_FILE"
    exit 1
fi

echo "No failure reported in $LOG_FILE"
exit 0
